/* compile.f */
logic/float_pkg.sv
logic/simd_pkg.sv
logic/fpmul_if.sv
logic/operand_dispatch.sv
logic/sig_mult.sv
logic/fpmul_lane.sv
logic/result_round.sv
logic/fpmul_simd_top.sv
test/fpmul_properties.sv
test/tb_fpmul_simd.sv

/* run_sim.sh */
#!/bin/sh
# Build the SIMD multiply testbench with Verilator and run it.
# The run counts as passed only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_fpmul_simd -Mdir obj_dir -f compile.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vtb_fpmul_simd > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Test OK$" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

/* test/tb_fpmul_simd.sv */
// ========================================
// SIMD float multiply testbench
// Random operand beats, credit-returning consumer and a reference model
// ========================================
`timescale 1ns/10ps
`default_nettype none

module tb_fpmul_simd;

    localparam int NUM_LANES   = 4;
    localparam int CORE_STAGES = 2;
    localparam int CREDITS     = 4;
    localparam int NUM_BEATS   = 3000;
    localparam int LATENCY     = 4 + CORE_STAGES;
    localparam int CYCLE_LIMIT = NUM_BEATS * 4 + 100;

    logic                        clk;
    logic                        rst_n;
    logic                        in_valid;
    logic [NUM_LANES-1:0][31:0]  op_a;
    logic [NUM_LANES-1:0][31:0]  op_b;
    logic                        in_ready;
    logic                        res_valid;
    logic [NUM_LANES-1:0][31:0]  res;
    simd_pkg::flags_t            res_flags;
    simd_pkg::flags_t            sticky_flags;
    logic                        flags_clr;
    logic                        res_credit;

    // Expected beats in acceptance order with the cycle they were taken
    logic [NUM_LANES*32-1:0] exp_res_q [$];
    logic [3:0]              exp_flags_q [$];
    int                      exp_cyc_q [$];
    // Each result the consumer still holds stands for one credit
    logic [NUM_LANES*32-1:0] rcv_q [$];

    int         cycle = 0;
    int         accepted = 0;
    int         returned = 0;
    int         burst_end = 0;
    logic [3:0] sticky_model = 4'd0;
    logic       clr_prev = 1'b0;

    fpmul_simd_top #(
        .NUM_LANES   (NUM_LANES),
        .CORE_STAGES (CORE_STAGES),
        .CREDITS     (CREDITS)
    ) u_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .in_valid_i     (in_valid),
        .op_a_i         (op_a),
        .op_b_i         (op_b),
        .in_ready_o     (in_ready),
        .res_valid_o    (res_valid),
        .res_o          (res),
        .res_flags_o    (res_flags),
        .sticky_flags_o (sticky_flags),
        .flags_clr_i    (flags_clr),
        .res_credit_i   (res_credit)
    );

    bind fpmul_simd_top fpmul_properties #(
        .CORE_STAGES (CORE_STAGES),
        .CREDITS     (CREDITS)
    ) u_props (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (in_valid_i),
        .in_ready_i   (in_ready_o),
        .res_valid_i  (res_valid_o),
        .res_credit_i (res_credit_i)
    );

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // ========================================
    // Reference model
    // ========================================
    // Returns {invalid, overflow, underflow, inexact, result}
    function automatic logic [35:0] mul_model(input logic [31:0] a, input logic [31:0] b);
        logic        sign;
        logic        a_nan;
        logic        a_inf;
        logic        b_nan;
        logic        b_inf;
        logic [47:0] prod;
        logic [23:0] keep;
        logic [23:0] rem;
        logic [23:0] half;
        logic        inc;
        int          e;
        sign  = a[31] ^ b[31];
        a_nan = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
        a_inf = (a[30:23] == 8'hff) && (a[22:0] == 23'd0);
        b_nan = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
        b_inf = (b[30:23] == 8'hff) && (b[22:0] == 23'd0);
        if (a_nan || b_nan || (a_inf && b[30:23] == 8'd0) || (b_inf && a[30:23] == 8'd0)) begin
            return {4'b1000, 32'h7fc00000};
        end
        if (a_inf || b_inf) begin
            return {4'b0000, sign, 8'hff, 23'd0};
        end
        // Subnormals count as zero
        if (a[30:23] == 8'd0 || b[30:23] == 8'd0) begin
            return {4'b0000, sign, 31'd0};
        end
        prod = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
        e    = int'(a[30:23]) + int'(b[30:23]) - 127;
        // The bits below the kept 23 are compared against exactly half an ulp
        if (prod[47]) begin
            e    = e + 1;
            keep = {1'b0, prod[46:24]};
            rem  = prod[23:0];
            half = 24'h800000;
        end else begin
            keep = {1'b0, prod[45:23]};
            rem  = {1'b0, prod[22:0]};
            half = 24'h400000;
        end
        if (e >= 255) begin
            return {4'b0100, sign, 8'hff, 23'd0};
        end
        if (e <= 0) begin
            return {4'b0010, sign, 31'd0};
        end
        inc  = (rem > half) || (rem == half && keep[0]);
        keep = keep + 24'(inc);
        if (keep[23]) begin
            e    = e + 1;
            keep = 24'd0;
        end
        if (e == 255) begin
            return {3'b010, rem != 24'd0, sign, 8'hff, 23'd0};
        end
        return {3'b000, rem != 24'd0, sign, 8'(e), keep[22:0]};
    endfunction

    // About one random word in four is swapped for an edge-case value
    function automatic logic [31:0] rand_operand();
        logic [31:0] r;
        r = $urandom();
        if ($urandom_range(3) != 0) begin
            return r;
        end
        case ($urandom_range(9))
            0:       return {r[31], 31'd0};
            1:       return {r[31], 8'd0, r[22:1], 1'b1};
            2:       return {r[31], 8'hff, 23'd0};
            3:       return {r[31], 8'hff, r[22:1], 1'b1};
            4:       return {r[31], 8'hfe, 23'h7fffff};
            5:       return {r[31], 8'h01, 23'd0};
            // 1.5 times one plus an odd number of ulps lands on a tie
            6:       return {r[31], 8'h7f, 23'h400000};
            7:       return {r[31], 8'h7f, 23'd1};
            // Times one plus one ulp this rounds up into the next binade or to infinity
            8:       return {r[31], r[0] ? 8'hfe : 8'h80, 23'h7ffffe};
            default: return {r[31], 8'h7f, 18'd0, r[4:1], 1'b1};
        endcase
    endfunction

    // ========================================
    // Clock, cycle count and timeout
    // ========================================
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            stop_with_failure($sformatf("Timeout: run did not finish within %0d cycles",
                                        CYCLE_LIMIT));
        end
    end

    // ========================================
    // Output checks at the falling edge
    // ========================================
    always @(negedge clk) begin : check_outputs
        logic [35:0]             m;
        logic [NUM_LANES*32-1:0] vec;
        logic [3:0]              fl;
        int                      acc_cyc;
        if (rst_n) begin
            assert (in_ready == ((CREDITS - accepted + returned) != 0))
                else stop_with_failure($sformatf("FAIL at %0t: in_ready %0b with %0d credits",
                                       $time, in_ready, CREDITS - accepted + returned));
            if (in_valid && in_ready) begin
                fl = 4'd0;
                for (int i = 0; i < NUM_LANES; i++) begin
                    m = mul_model(op_a[i], op_b[i]);
                    vec[i*32 +: 32] = m[31:0];
                    fl = fl | m[35:32];
                end
                exp_res_q.push_back(vec);
                exp_flags_q.push_back(fl);
                exp_cyc_q.push_back(cycle);
                accepted++;
            end
            fl = 4'd0;
            if (res_valid) begin
                assert (exp_res_q.size() != 0)
                    else stop_with_failure("A result came out with no beat outstanding");
                vec     = exp_res_q.pop_front();
                fl      = exp_flags_q.pop_front();
                acc_cyc = exp_cyc_q.pop_front();
                assert (cycle - acc_cyc == LATENCY)
                    else stop_with_failure($sformatf("FAIL at %0t: result %0d cycles after accept",
                                           $time, cycle - acc_cyc));
                assert (res == vec)
                    else stop_with_failure($sformatf("FAIL at %0t: result %h, expected %h",
                                           $time, res, vec));
                assert (res_flags == fl)
                    else stop_with_failure($sformatf("FAIL at %0t: flags %b, expected %b",
                                           $time, res_flags, fl));
                rcv_q.push_back(vec);
            end
            // A clear on the previous edge wins over a result on that edge
            if (clr_prev) begin
                sticky_model = 4'd0;
            end else begin
                sticky_model = sticky_model | fl;
            end
            assert (sticky_flags == sticky_model)
                else stop_with_failure($sformatf("FAIL at %0t: sticky flags %b, expected %b",
                                       $time, sticky_flags, sticky_model));
            clr_prev = flags_clr;
            if (res_credit) begin
                returned++;
            end
        end
    end

    // ========================================
    // Stimulus and consumer
    // ========================================
    initial begin
        void'($urandom(32'h2e170957));
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        op_a       = '0;
        op_b       = '0;
        flags_clr  = 1'b0;
        res_credit = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_n     = 1'b1;
        // Opening burst with no returns runs the credits out
        burst_end = cycle + 12;
        do begin
            @(posedge clk);
            #2;
            in_valid = (accepted < NUM_BEATS) && (cycle <= burst_end || $urandom_range(3) != 0);
            for (int i = 0; i < NUM_LANES; i++) begin
                op_a[i] = rand_operand();
                op_b[i] = rand_operand();
            end
            flags_clr  = ($urandom_range(31) == 0);
            res_credit = (rcv_q.size() != 0) && (cycle > burst_end) && ($urandom_range(3) != 0);
            if (res_credit) begin
                void'(rcv_q.pop_front());
            end
        end while (accepted < NUM_BEATS || exp_res_q.size() != 0 || rcv_q.size() != 0);
        @(posedge clk);
        #2;
        in_valid   = 1'b0;
        res_credit = 1'b0;
        flags_clr  = 1'b0;
        @(posedge clk);
        #2;
        assert (accepted == NUM_BEATS && returned == NUM_BEATS && in_ready)
            else stop_with_failure("Run ended with beats or credits unaccounted for");
        $display("Test OK");
        $finish;
    end

endmodule : tb_fpmul_simd

`default_nettype wire

/* test/fpmul_properties.sv */
// ========================================
// Unit properties
// Credit, latency and reset rules checked on the top-level handshake
// ========================================
`timescale 1ns/10ps
`default_nettype none

module fpmul_properties #(
    parameter int CORE_STAGES = 2,
    parameter int CREDITS     = 4
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  in_valid_i,
    input  logic  in_ready_i,
    input  logic  res_valid_i,
    input  logic  res_credit_i
);

    localparam int LATENCY = 4 + CORE_STAGES;

    int                 credits;
    logic [LATENCY-1:0] acc_pipe;

    // Credit count rebuilt from the handshake alone
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credits  <= CREDITS;
            acc_pipe <= '0;
        end else begin
            credits  <= credits + int'(res_credit_i) - int'(in_valid_i & in_ready_i);
            acc_pipe <= {acc_pipe[LATENCY-2:0], in_valid_i & in_ready_i};
        end
    end

    // Ready is high exactly while a result slot is free
    ready_tracks_credits : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_ready_i == (credits != 0))
        else $error("in_ready does not match the credit count");

    // Every accepted beat comes out a fixed number of cycles later
    result_follows_accept : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_valid_i == acc_pipe[LATENCY-1])
        else $error("res_valid does not follow acceptance by the pipeline latency");

    // No result leaves while reset is held
    quiet_in_reset : assert property (@(posedge clk_i)
        !rst_n_i && $past(!rst_n_i) |-> !res_valid_i)
        else $error("res_valid is high during reset");

endmodule : fpmul_properties

`default_nettype wire

/* logic/fpmul_simd_top.sv */
// ========================================
// SIMD float multiply unit
// Credit-gated dispatch, NUM_LANES multiply lanes and a rounding collector
// ========================================
`timescale 1ns/10ps
`default_nettype none

module fpmul_simd_top #(
    parameter int NUM_LANES   = 4,
    parameter int CORE_STAGES = 2,
    parameter int CREDITS     = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    // Operand beat
    input  logic                        in_valid_i,
    input  logic [NUM_LANES-1:0][31:0]  op_a_i,
    input  logic [NUM_LANES-1:0][31:0]  op_b_i,
    output logic                        in_ready_o,
    // Result beat, 4+CORE_STAGES cycles after acceptance
    output logic                        res_valid_o,
    output logic [NUM_LANES-1:0][31:0]  res_o,
    output simd_pkg::flags_t            res_flags_o,
    output simd_pkg::flags_t            sticky_flags_o,
    input  logic                        flags_clr_i,
    // One pulse returns one result slot
    input  logic                        res_credit_i
);

    lane_req_if req_if [NUM_LANES] ();
    lane_rsp_if rsp_if [NUM_LANES] ();

    operand_dispatch #(
        .NUM_LANES (NUM_LANES),
        .CREDITS   (CREDITS)
    ) u_dispatch (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (in_valid_i),
        .op_a_i       (op_a_i),
        .op_b_i       (op_b_i),
        .res_credit_i (res_credit_i),
        .in_ready_o   (in_ready_o),
        .req_o        (req_if)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        fpmul_lane #(
            .CORE_STAGES (CORE_STAGES)
        ) u_lane (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .req_i   (req_if[g]),
            .rsp_o   (rsp_if[g])
        );
    end

    result_round #(
        .NUM_LANES (NUM_LANES)
    ) u_round (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flags_clr_i    (flags_clr_i),
        .rsp_i          (rsp_if),
        .res_valid_o    (res_valid_o),
        .res_o          (res_o),
        .res_flags_o    (res_flags_o),
        .sticky_flags_o (sticky_flags_o)
    );

endmodule : fpmul_simd_top

`default_nettype wire

/* logic/result_round.sv */
// ========================================
// Result collector
// Nearest-even rounding per lane, result vector and sticky flags
// ========================================
`timescale 1ns/10ps
`default_nettype none

module result_round #(
    parameter int NUM_LANES = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flags_clr_i,
    lane_rsp_if.collect                 rsp_i [NUM_LANES],
    output logic                        res_valid_o,
    output logic [NUM_LANES-1:0][31:0]  res_o,
    output simd_pkg::flags_t            res_flags_o,
    output simd_pkg::flags_t            sticky_flags_o
);

    float_pkg::float_t rounded    [NUM_LANES];
    simd_pkg::flags_t  lane_flags [NUM_LANES];
    simd_pkg::flags_t  flags_or;
    logic              beat_valid;

    // ========================================
    // Per-lane rounding
    // ========================================
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        float_pkg::float_t      in_res;
        float_pkg::round_bits_t rb;
        logic                   inc;
        logic [23:0]            sig_sum;
        logic [7:0]             exp_sum;
        logic                   rnd_ovf;

        assign in_res = rsp_i[g].result;
        assign rb     = rsp_i[g].rbits;

        // Round up above half, or on a tie when the LSB is odd
        assign inc     = rb.guard & (rb.round | rb.sticky | in_res.significand[0]);
        assign sig_sum = {1'b0, in_res.significand} + 24'(inc);
        assign exp_sum = in_res.exponent + 8'(sig_sum[23]);

        // Special results carry zero round bits, so only a real carry gets here
        assign rnd_ovf = sig_sum[23] & (exp_sum == 8'(float_pkg::EXP_MAX));

        // A carry clears the fraction, so a carry into EXP_MAX already reads as infinity
        assign rounded[g] = '{sign: in_res.sign, exponent: exp_sum,
                              significand: sig_sum[22:0]};

        assign lane_flags[g] = '{invalid:   rsp_i[g].invalid,
                                 overflow:  rsp_i[g].overflow | rnd_ovf,
                                 underflow: rsp_i[g].underflow,
                                 inexact:   |rb};
    end

    // ========================================
    // Beat assembly
    // ========================================
    // All lanes run in lockstep, lane 0 speaks for the beat
    assign beat_valid = rsp_i[0].valid;

    always_comb begin
        flags_or = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            flags_or = flags_or | lane_flags[i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_valid_o    <= 1'b0;
            sticky_flags_o <= '0;
        end else begin
            res_valid_o <= beat_valid;
            // A clear beats a result arriving on the same edge
            if (flags_clr_i) begin
                sticky_flags_o <= '0;
            end else if (beat_valid) begin
                sticky_flags_o <= sticky_flags_o | flags_or;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (beat_valid) begin
            res_flags_o <= flags_or;
            for (int i = 0; i < NUM_LANES; i++) begin
                res_o[i] <= rounded[i];
            end
        end
    end

endmodule : result_round

`default_nettype wire

/* logic/fpmul_lane.sv */
// ========================================
// Multiply lane
// Pipelined binary32 multiply, truncated result with round bits and flags
// ========================================
`timescale 1ns/10ps
`default_nettype none

module fpmul_lane #(
    parameter int CORE_STAGES = 2
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    lane_req_if.lane  req_i,
    lane_rsp_if.lane  rsp_o
);

    // Term word is {sign, exponent[9:0], invalid, any_inf, any_zero}
    localparam int TW = 14;

    // ========================================
    // Stage 0
    // ========================================
    logic signed [9:0] exp_in;
    logic              invalid_in;
    logic [TW-1:0]     term_in;

    // Unbiased sum, signed so that underflow shows up as a value at or below zero
    assign exp_in = $signed({2'b00, req_i.a.exponent}) + $signed({2'b00, req_i.b.exponent})
                  - 10'(float_pkg::BIAS);

    // NaN times anything, or infinity times zero
    assign invalid_in = req_i.a_is_nan | req_i.b_is_nan
                      | (req_i.a_is_inf & req_i.b_is_zero)
                      | (req_i.b_is_inf & req_i.a_is_zero);

    assign term_in = {req_i.a.sign ^ req_i.b.sign, exp_in, invalid_in,
                      req_i.a_is_inf | req_i.b_is_inf, req_i.a_is_zero | req_i.b_is_zero};

    logic [23:0]   sig_a_q;
    logic [23:0]   sig_b_q;
    logic [TW-1:0] term_q;
    logic          vld_q;

    // Hidden bit comes from a nonzero exponent
    always_ff @(posedge clk_i) begin
        sig_a_q <= {|req_i.a.exponent, req_i.a.significand};
        sig_b_q <= {|req_i.b.exponent, req_i.b.significand};
        term_q  <= term_in;
    end

    // ========================================
    // Core and side pipeline
    // ========================================
    logic [47:0]                prod;
    logic [47:0]                prod_q;
    logic [CORE_STAGES:0][TW-1:0] term_pipe;
    logic [CORE_STAGES:0]       vld_pipe;

    sig_mult #(
        .CORE_STAGES (CORE_STAGES)
    ) u_core (
        .clk_i (clk_i),
        .a_i   (sig_a_q),
        .b_i   (sig_b_q),
        .p_o   (prod)
    );

    // Terms ride CORE_STAGES+1 registers so they meet the product register
    always_ff @(posedge clk_i) begin
        prod_q       <= prod;
        term_pipe[0] <= term_q;
        for (int i = 1; i <= CORE_STAGES; i++) begin
            term_pipe[i] <= term_pipe[i-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            vld_q    <= 1'b0;
            vld_pipe <= '0;
        end else begin
            vld_q       <= req_i.valid;
            vld_pipe[0] <= vld_q;
            for (int i = 1; i <= CORE_STAGES; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    // ========================================
    // Normalise and resolve
    // ========================================
    logic                   t_sign;
    logic signed [9:0]      t_exp;
    logic                   t_invalid;
    logic                   t_inf;
    logic                   t_zero;
    logic signed [9:0]      exp_n;
    logic [22:0]            frac_n;
    float_pkg::round_bits_t rb_n;

    assign {t_sign, t_exp, t_invalid, t_inf, t_zero} = term_pipe[CORE_STAGES];

    // A product at or above 2.0 shifts right by one and bumps the exponent
    always_comb begin
        if (prod_q[47]) begin
            exp_n  = t_exp + 10'sd1;
            frac_n = prod_q[46:24];
            rb_n   = '{guard: prod_q[23], round: prod_q[22], sticky: |prod_q[21:0]};
        end else begin
            exp_n  = t_exp;
            frac_n = prod_q[45:23];
            rb_n   = '{guard: prod_q[22], round: prod_q[21], sticky: |prod_q[20:0]};
        end
    end

    always_comb begin
        rsp_o.result    = '{sign: t_sign, exponent: exp_n[7:0], significand: frac_n};
        rsp_o.rbits     = '0;
        rsp_o.invalid   = 1'b0;
        rsp_o.overflow  = 1'b0;
        rsp_o.underflow = 1'b0;
        // Priority follows the special-case table, top row first
        if (t_invalid) begin
            rsp_o.result  = float_pkg::CANONICAL_NAN;
            rsp_o.invalid = 1'b1;
        end else if (t_inf) begin
            rsp_o.result = '{sign: t_sign, exponent: 8'hff, significand: 23'd0};
        end else if (t_zero) begin
            rsp_o.result = '{sign: t_sign, exponent: 8'd0, significand: 23'd0};
        end else if (exp_n >= float_pkg::EXP_MAX) begin
            rsp_o.result   = '{sign: t_sign, exponent: 8'hff, significand: 23'd0};
            rsp_o.overflow = 1'b1;
        end else if (exp_n <= 10'sd0) begin
            // No gradual underflow, tiny results collapse to signed zero
            rsp_o.result    = '{sign: t_sign, exponent: 8'd0, significand: 23'd0};
            rsp_o.underflow = 1'b1;
        end else begin
            rsp_o.rbits = rb_n;
        end
    end

    assign rsp_o.valid = vld_pipe[CORE_STAGES];

endmodule : fpmul_lane

`default_nettype wire

/* logic/sig_mult.sv */
// ========================================
// Significand multiplier
// 24x24 product with a configurable register chain
// ========================================
`timescale 1ns/10ps
`default_nettype none

module sig_mult #(
    parameter int CORE_STAGES = 2
) (
    input  logic        clk_i,
    input  logic [23:0] a_i,
    input  logic [23:0] b_i,
    output logic [47:0] p_o
);

    if (CORE_STAGES == 0) begin : g_comb
        // Purely combinational core
        assign p_o = a_i * b_i;
    end else begin : g_piped
        logic [CORE_STAGES-1:0][47:0] prod_q;

        // The retiming tool is free to spread the product over these registers
        always_ff @(posedge clk_i) begin
            prod_q[0] <= a_i * b_i;
            for (int i = 1; i < CORE_STAGES; i++) begin
                prod_q[i] <= prod_q[i-1];
            end
        end

        assign p_o = prod_q[CORE_STAGES-1];
    end

endmodule : sig_mult

`default_nettype wire

/* logic/operand_dispatch.sv */
// ========================================
// Operand dispatcher
// Credit counter, operand classification and registered lane requests
// ========================================
`timescale 1ns/10ps
`default_nettype none

module operand_dispatch #(
    parameter int NUM_LANES = 4,
    parameter int CREDITS   = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        in_valid_i,
    input  logic [NUM_LANES-1:0][31:0]  op_a_i,
    input  logic [NUM_LANES-1:0][31:0]  op_b_i,
    input  logic                        res_credit_i,
    output logic                        in_ready_o,
    lane_req_if.dispatch                req_o [NUM_LANES]
);

    localparam int CW = $clog2(CREDITS + 1);

    // Class bits as {nan, inf, zero}, subnormals fall into zero
    function automatic logic [2:0] classify(float_pkg::float_t f);
        logic exp_ones;
        logic sig_zero;
        exp_ones = &f.exponent;
        sig_zero = (f.significand == 23'd0);
        return {exp_ones & !sig_zero, exp_ones & sig_zero, f.exponent == 8'd0};
    endfunction

    // Any operand with a zero exponent leaves as a signed zero
    function automatic float_pkg::float_t flush_sub(float_pkg::float_t f);
        float_pkg::float_t r;
        r = f;
        if (f.exponent == 8'd0) begin
            r.significand = 23'd0;
        end
        return r;
    endfunction

    // ========================================
    // Credits
    // ========================================
    logic [CW-1:0] credit_q;
    logic          accept;

    // Each credit is one free result slot at the consumer
    assign in_ready_o = (credit_q != '0);
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credit_q <= CW'(CREDITS);
        end else begin
            // Accept and return can land on the same edge and cancel out
            credit_q <= credit_q + CW'(res_credit_i) - CW'(accept);
        end
    end

    // ========================================
    // Lane requests
    // ========================================
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        logic [2:0] cls_a;
        logic [2:0] cls_b;

        assign cls_a = classify(op_a_i[g]);
        assign cls_b = classify(op_b_i[g]);

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                req_o[g].valid <= 1'b0;
            end else begin
                req_o[g].valid <= accept;
            end
        end

        // Payload is only loaded on an accepted beat
        always_ff @(posedge clk_i) begin
            if (accept) begin
                req_o[g].a         <= flush_sub(op_a_i[g]);
                req_o[g].b         <= flush_sub(op_b_i[g]);
                req_o[g].a_is_nan  <= cls_a[2];
                req_o[g].a_is_inf  <= cls_a[1];
                req_o[g].a_is_zero <= cls_a[0];
                req_o[g].b_is_nan  <= cls_b[2];
                req_o[g].b_is_inf  <= cls_b[1];
                req_o[g].b_is_zero <= cls_b[0];
            end
        end
    end

endmodule : operand_dispatch

`default_nettype wire

/* logic/fpmul_if.sv */
// ========================================
// Lane interfaces
// Request into a multiply lane and its response to the collector
// ========================================
`timescale 1ns/10ps
`default_nettype none

// Classified operand pair, no back-pressure
interface lane_req_if;
    logic               valid;
    float_pkg::float_t  a;
    float_pkg::float_t  b;
    // Class bits, subnormals are already zeroed and marked as zero
    logic               a_is_nan;
    logic               a_is_inf;
    logic               a_is_zero;
    logic               b_is_nan;
    logic               b_is_inf;
    logic               b_is_zero;

    modport dispatch (output valid, a, b, a_is_nan, a_is_inf, a_is_zero,
                      b_is_nan, b_is_inf, b_is_zero);
    modport lane (input valid, a, b, a_is_nan, a_is_inf, a_is_zero,
                  b_is_nan, b_is_inf, b_is_zero);
endinterface : lane_req_if

// Truncated lane result with round bits and the lane exception terms
interface lane_rsp_if;
    logic                    valid;
    float_pkg::float_t       result;
    float_pkg::round_bits_t  rbits;
    logic                    invalid;
    logic                    overflow;
    logic                    underflow;

    modport lane (output valid, result, rbits, invalid, overflow, underflow);
    modport collect (input valid, result, rbits, invalid, overflow, underflow);
endinterface : lane_rsp_if

`default_nettype wire

/* logic/simd_pkg.sv */
// ========================================
// SIMD unit package
// Exception flag record reported per beat
// ========================================
`default_nettype none

package simd_pkg;

    // Exception flags, ORed over all lanes of a beat
    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
        logic inexact;
    } flags_t;

endpackage : simd_pkg

`default_nettype wire

/* logic/float_pkg.sv */
// ========================================
// Float format package
// Binary32 field layout, round bits and the format constants
// ========================================
`default_nettype none

package float_pkg;

    // Binary32 word split into its three fields
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] significand;
    } float_t;

    // Bits below the result LSB, kept for the rounding stage
    typedef struct packed {
        logic guard;
        logic round;
        logic sticky;
    } round_bits_t;

    // Exponent bias of binary32
    localparam int BIAS = 127;

    // Biased exponent shared by infinity and NaN
    localparam int EXP_MAX = 255;

    // Quiet NaN returned by every invalid operation
    localparam float_t CANONICAL_NAN = '{sign: 1'b0, exponent: 8'hff, significand: 23'h400000};

endpackage : float_pkg

`default_nettype wire
